// ==== filelist.f ====
verilog/rtcPkg.sv
verilog/rtcFieldIf.sv
verilog/fieldSelect.sv
verilog/bcdFieldReg.sv
verilog/readbackMux.sv
verilog/rtcRegBank.sv
testbench/rtcRegBankTb.sv

// ==== testbench/rtcRegBankTb.sv ====
// RTC register bank testbench with clock, reset, stimulus, reference model, checker and watchdog
`timescale 1ns/10ps
`default_nettype none

module rtcRegBankTb;

	// Slot tables in year, month, day, hour, minute, second and timer order
	localparam logic [7:0] addrTab [9] = '{8'h26, 8'h25, 8'h24, 8'h23, 8'h22, 8'h21,
		8'h43, 8'h42, 8'h41};
	localparam logic [7:0] minTab [9] = '{8'h00, 8'h01, 8'h01, 8'h00, 8'h00, 8'h00,
		8'h00, 8'h00, 8'h00};
	localparam logic [7:0] maxTab [9] = '{8'h99, 8'h12, 8'h31, 8'h23, 8'h59, 8'h59,
		8'h23, 8'h59, 8'h59};
	// Cycles for reset, idle, load, readback, step, random and drain
	localparam int stimCycles = 2 + 2 + 27 + 20 + 126 + 400 + 3;

	logic        CLK;
	logic        rstN;
	logic        envAddress;
	logic        recvData;
	logic        envData;
	logic [6:0]  pointer;
	logic [7:0]  address;
	logic [7:0]  busIn;
	logic        modify;
	logic        up;
	logic        down;
	logic [7:0]  busOut;
	logic        busOe;
	logic [7:0]  year, month, day, hour, minute, second;
	logic [7:0]  timerHour, timerMinute, timerSecond;
	logic [71:0] dutFields;                            // Field outputs with slot 0 in the low byte
	logic [71:0] model;                                // Expected field contents
	logic [7:0]  modelAddr;                            // Expected latched address
	logic [8:0]  busExp;                               // Expected {busOe, busOut}
	logic        checking;                             // Checker enabled after reset
	string       fieldName [9] = '{"year", "month", "day", "hour", "minute", "second",
		"timerHour", "timerMinute", "timerSecond"};

	assign dutFields = {timerSecond, timerMinute, timerHour, second, minute, hour,
		day, month, year};

	rtcRegBank rtcRegBank_i
	(
		.CLK(CLK), .rstN(rstN), .envAddress(envAddress), .recvData(recvData), .envData(envData),
		.pointer(pointer), .address(address), .busIn(busIn), .modify(modify), .up(up),
		.down(down), .busOut(busOut), .busOe(busOe), .year(year), .month(month), .day(day),
		.hour(hour), .minute(minute), .second(second), .timerHour(timerHour),
		.timerMinute(timerMinute), .timerSecond(timerSecond)
	);

	initial
	begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;                         // 8 ns period
	end

	//////////////////////////////////////////////////
	// Reference model

	function automatic logic [7:0] stepField(input logic [7:0] v, input int s, input logic inc);
		if (inc)
		begin
			if (v >= maxTab[s])
				return minTab[s];                      // Wrap past the top
			if (v[3:0] == 4'd9)
				return {v[7:4] + 4'd1, 4'd0};         // Carry into tens
			return {v[7:4], v[3:0] + 4'd1};
		end
		if (v <= minTab[s])
			return maxTab[s];                          // Wrap below the bottom
		if (v[3:0] == 4'd0)
			return {v[7:4] - 4'd1, 4'd9};             // Borrow from tens
		return {v[7:4], v[3:0] - 4'd1};
	endfunction

	function automatic logic [71:0] nextFields(input logic [71:0] cur, input logic [7:0] la,
		input logic rD, input logic [7:0] data, input logic [6:0] ptr, input logic mod,
		input logic u, input logic d);
		logic [71:0] nxt;
		nxt = cur;
		for (int s = 0; s < 9; s++)
		begin
			if (rD && la == addrTab[s])
				nxt[s*8 +: 8] = data;                  // Load beats stepping
			else if (mod && {1'b0, ptr} == addrTab[s] && (u ^ d))
				nxt[s*8 +: 8] = stepField(cur[s*8 +: 8], s, u);
		end
		return nxt;
	endfunction

	function automatic logic [8:0] expectBus(input logic [71:0] flds, input logic [7:0] la,
		input logic eA, input logic eD, input logic [7:0] addr);
		logic [7:0] word;
		word = 8'hFF;                                  // No matching field
		for (int s = 0; s < 9; s++)
		begin
			if (la == addrTab[s])
				word = flds[s*8 +: 8];
		end
		if (eA)
			word = addr;                               // Address phase shows the address
		return {eA | eD, word};
	endfunction

	task automatic checkValue(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (exp !== act)
		begin
			$display("FAIL at %0d ns: %s expected %h, got %h", $time, name, exp, act);
			$display("Simulation failed");
			$fatal(1, "output mismatch");
		end
	endtask

	// Compare in the quiet part of each cycle, then advance the model over the coming edge
	always
	begin
		@(posedge CLK);
		#6;
		if (checking)
		begin
			for (int s = 0; s < 9; s++)
				checkValue(fieldName[s], model[s*8 +: 8], dutFields[s*8 +: 8]);
			busExp = expectBus(model, modelAddr, envAddress, envData, address);
			checkValue("busOut", busExp[7:0], busOut);
			checkValue("busOe", {7'd0, busExp[8]}, {7'd0, busOe});
			model = nextFields(model, modelAddr, recvData, busIn, pointer, modify, up, down);
			if (envAddress)
				modelAddr = address;                   // Latch takes effect at the edge
		end
	end

	//////////////////////////////////////////////////
	// Stimulus helpers

	function automatic logic [7:0] randBcd();
		return {4'($urandom % 10), 4'($urandom % 10)};
	endfunction

	task automatic applyInputs(input logic eA, input logic rD, input logic eD,
		input logic [7:0] addr, input logic [7:0] data, input logic [6:0] ptr,
		input logic mod, input logic u, input logic d);
		@(posedge CLK);
		#1;                                            // Clear of the sampling edge
		envAddress = eA;
		recvData   = rD;
		envData    = eD;
		address    = addr;
		busIn      = data;
		pointer    = ptr;
		modify     = mod;
		up         = u;
		down       = d;
	endtask

	task automatic loadField(input logic [7:0] addr, input logic [7:0] data);
		applyInputs(1'b1, 1'b0, 1'b0, addr, 8'h00, 7'h00, 1'b0, 1'b0, 1'b0);
		applyInputs(1'b0, 1'b1, 1'b0, addr, data, 7'h00, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic stepRun(input logic [6:0] ptr, input logic u, input logic d, input int n);
		repeat (n)
			applyInputs(1'b0, 1'b0, 1'b0, 8'h00, 8'h00, ptr, 1'b1, u, d);
	endtask

	//////////////////////////////////////////////////
	// Test sequence

	initial
	begin
		void'($urandom(48));
		{envAddress, recvData, envData, modify, up, down} = 6'b0;
		{pointer, address, busIn} = 23'h0;
		rstN      = 1'b0;
		checking  = 1'b0;
		modelAddr = 8'h00;
		for (int s = 0; s < 9; s++)
			model[s*8 +: 8] = minTab[s];               // Reset contents
		repeat (2) @(posedge CLK);
		#1;
		rstN     = 1'b1;
		checking = 1'b1;
		applyInputs(1'b0, 1'b0, 1'b0, 8'h00, 8'h00, 7'h00, 1'b0, 1'b0, 1'b0);
		applyInputs(1'b0, 1'b0, 1'b1, 8'h00, 8'h00, 7'h00, 1'b0, 1'b0, 1'b0);   // No address yet
		for (int s = 0; s < 9; s++)
		begin
			loadField(addrTab[s], randBcd());
			applyInputs(1'b0, 1'b0, 1'b0, 8'h00, 8'h00, 7'h00, 1'b0, 1'b0, 1'b0);
		end
		for (int s = 0; s <= 9; s++)
		begin
			// Last pass uses an unmapped address
			applyInputs(1'b1, 1'b0, 1'b0, (s < 9) ? addrTab[s] : 8'h30, 8'h00, 7'h00,
				1'b0, 1'b0, 1'b0);
			applyInputs(1'b0, 1'b0, 1'b1, 8'h00, 8'h00, 7'h00, 1'b0, 1'b0, 1'b0);
		end
		for (int s = 0; s < 9; s++)
		begin
			loadField(addrTab[s], 8'h08);
			stepRun(addrTab[s][6:0], 1'b1, 1'b0, 3);    // 08 to 11 through the carry
			stepRun(addrTab[s][6:0], 1'b0, 1'b1, 3);    // Back through the borrow
			loadField(addrTab[s], maxTab[s]);
			stepRun(addrTab[s][6:0], 1'b1, 1'b0, 1);    // Wrap to min
			stepRun(addrTab[s][6:0], 1'b0, 1'b1, 1);    // Wrap to max
			stepRun(addrTab[s][6:0], 1'b1, 1'b1, 1);    // Both cancel
			stepRun(7'h30, 1'b1, 1'b0, 1);              // Unmapped pointer
		end
		repeat (400)
		begin
			applyInputs(($urandom % 4) == 0, ($urandom % 3) == 0, ($urandom % 4) == 0,
				($urandom % 2) ? addrTab[$urandom % 9] : 8'($urandom), randBcd(),
				($urandom % 4) ? addrTab[$urandom % 9][6:0] : 7'($urandom),
				1'($urandom), 1'($urandom), 1'($urandom));
		end
		applyInputs(1'b0, 1'b0, 1'b0, 8'h00, 8'h00, 7'h00, 1'b0, 1'b0, 1'b0);
		repeat (2) @(posedge CLK);
		#7;                                            // Let the last checks run
		$display("Simulation passed");
		$finish;
	end

	initial
	begin
		#(2 * stimCycles * 8);
		$display("Timeout: the test sequence did not finish in time");
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// ==== verilog/rtcRegBank.sv ====
// RTC register bank top level with selector, nine BCD field registers and readback mux
`timescale 1ns/10ps
`default_nettype none

module rtcRegBank
	import rtcPkg::*;
	(
	input  logic       CLK,
	input  logic       rstN,
	input  logic       envAddress,                  // Send address strobe
	input  logic       recvData,                    // Receive data strobe
	input  logic       envData,                     // Send data strobe
	input  logic [6:0] pointer,                     // Edit pointer
	input  logic [7:0] address,                     // RTC register address
	input  logic [7:0] busIn,                       // Bus data from pad
	input  logic       modify,                      // Edit mode
	input  logic       up,
	input  logic       down,
	output logic [7:0] busOut,                      // Bus data to pad
	output logic       busOe,                       // Pad output enable
	output logic [7:0] year,
	output logic [7:0] month,
	output logic [7:0] day,
	output logic [7:0] hour,
	output logic [7:0] minute,
	output logic [7:0] second,
	output logic [7:0] timerHour,
	output logic [7:0] timerMinute,
	output logic [7:0] timerSecond
	);

	busWordU addressWord;                             // Address port as bus word
	busWordU busInWord;                               // Incoming data as bus word
	busWordU busOutWord;                              // Readback word
	busWordU latchedAddr;                             // Selector address register

	rtcFieldIf fieldIf [fieldCount] ();                // One bundle per slot

	assign addressWord = address;
	assign busInWord   = busIn;
	assign busOut      = busOutWord.raw;

	//////////////////////////////////////////////////
	// Decode, storage and readback

	fieldSelect fieldSelect_i
	(
		.CLK        (CLK),
		.rstN       (rstN),
		.envAddress (envAddress),
		.recvData   (recvData),
		.address    (addressWord),
		.pointer    (pointer),
		.modify     (modify),
		.latchedAddr(latchedAddr),
		.fields     (fieldIf)
	);

	genvar g;
	generate
		for (g = 0; g < fieldCount; g++)
		begin : fieldRegs
			bcdFieldReg #(.slot(g)) bcdFieldReg_i
			(
				.CLK  (CLK),
				.rstN (rstN),
				.busIn(busInWord),
				.up   (up),
				.down (down),
				.field(fieldIf[g])
			);
		end
	endgenerate

	readbackMux readbackMux_i
	(
		.envAddress (envAddress),
		.envData    (envData),
		.address    (addressWord),
		.latchedAddr(latchedAddr),
		.fields     (fieldIf),
		.busOut     (busOutWord),
		.busOe      (busOe)
	);

	//////////////////////////////////////////////////
	// Display outputs in the slot order of the address table

	assign year        = fieldIf[0].value;
	assign month       = fieldIf[1].value;
	assign day         = fieldIf[2].value;
	assign hour        = fieldIf[3].value;
	assign minute      = fieldIf[4].value;
	assign second      = fieldIf[5].value;
	assign timerHour   = fieldIf[6].value;
	assign timerMinute = fieldIf[7].value;
	assign timerSecond = fieldIf[8].value;

endmodule

`default_nettype wire

// ==== verilog/readbackMux.sv ====
// Bus output select between sent address and the field matching the latched address
`timescale 1ns/10ps
`default_nettype none

module readbackMux
	import rtcPkg::*;
	(
	input  logic        envAddress,                 // Address send strobe
	input  logic        envData,                    // Data send strobe
	input  busWordU     address,                    // Address byte from host
	input  busWordU     latchedAddr,                // Address held by the selector
	rtcFieldIf.readback fields [fieldCount],        // Field values
	output busWordU     busOut,                     // Word driven toward the RTC
	output logic        busOe                       // Bus drive enable
	);

	bcdByteT slotValue [fieldCount];                  // Field values as a plain array

	// Flatten interface array so the search loop can index it
	genvar g;
	generate
		for (g = 0; g < fieldCount; g++)
		begin : slotGather
			assign slotValue[g] = fields[g].value;
		end
	endgenerate

	//////////////////////////////////////////////////
	// Readback word

	always_comb
	begin
		busOut.raw = noFieldWord;                     // Unknown address reads FF
		for (int i = 0; i < fieldCount; i++)
		begin
			if (latchedAddr.raw == fieldAddr[i])
			begin
				busOut.bcd = slotValue[i];            // Matching field
			end
		end
		if (envAddress)
		begin
			busOut = address;                         // Address phase overrides data
		end
	end

	assign busOe = envAddress | envData;              // Drive during either send strobe

endmodule

`default_nettype wire

// ==== verilog/bcdFieldReg.sv ====
// One BCD time field register with bus load and wrapping up/down step
`timescale 1ns/10ps
`default_nettype none

module bcdFieldReg
	import rtcPkg::*;
	#(
	parameter int slot = 0                          // Picks limits from the package tables
	)
	(
	input  logic    CLK,
	input  logic    rstN,
	input  busWordU busIn,                          // Data byte from the RTC bus
	input  logic    up,                             // Step up request
	input  logic    down,                           // Step down request
	rtcFieldIf.field field                          // Strobes in, value out
	);

	//////////////////////////////////////////////////
	// Slot limits

	localparam bcdByteT minVal = fieldMin[slot];     // Lowest legal value and reset value
	localparam bcdByteT maxVal = fieldMax[slot];     // Highest legal value

	bcdByteT incVal;                                  // Value after one step up
	bcdByteT decVal;                                  // Value after one step down
	logic    stepUp;                                  // Exactly up requested
	logic    stepDown;                                // Exactly down requested

	assign stepUp   = field.modify & up & ~down;
	assign stepDown = field.modify & down & ~up;      // Both high cancels out

	//////////////////////////////////////////////////
	// BCD increment and decrement with wrap

	always_comb
	begin
		if (field.value >= maxVal)
		begin
			incVal = minVal;                          // Wrap past the top
		end
		else if (field.value.ones == 4'd9)
		begin
			incVal.tens = field.value.tens + 4'd1;    // Carry into tens
			incVal.ones = 4'd0;
		end
		else
		begin
			incVal.tens = field.value.tens;
			incVal.ones = field.value.ones + 4'd1;
		end
	end

	always_comb
	begin
		if (field.value <= minVal)
		begin
			decVal = maxVal;                          // Wrap below the bottom
		end
		else if (field.value.ones == 4'd0)
		begin
			decVal.tens = field.value.tens - 4'd1;    // Borrow from tens
			decVal.ones = 4'd9;
		end
		else
		begin
			decVal.tens = field.value.tens;
			decVal.ones = field.value.ones - 4'd1;
		end
	end

	//////////////////////////////////////////////////
	// Field storage

	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
		begin
			field.value <= minVal;
		end
		else if (field.load)
		begin
			field.value <= busIn.bcd;                 // Bus load wins over stepping
		end
		else if (stepUp)
		begin
			field.value <= incVal;
		end
		else if (stepDown)
		begin
			field.value <= decVal;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/fieldSelect.sv ====
// Address latch and per-field load/modify decode from latched address and edit pointer
`timescale 1ns/10ps
`default_nettype none

module fieldSelect
	import rtcPkg::*;
	(
	input  logic       CLK,
	input  logic       rstN,
	input  logic       envAddress,                  // Address send strobe
	input  logic       recvData,                    // Data receive strobe
	input  busWordU    address,                     // Address byte from host
	input  logic [6:0] pointer,                     // Edit pointer holding an RTC address
	input  logic       modify,                      // Manual edit enable
	output busWordU    latchedAddr,                 // Address held for data phases
	rtcFieldIf.select  fields [fieldCount]          // Per-field strobes
	);

	//////////////////////////////////////////////////
	// Address latch

	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
		begin
			latchedAddr.raw <= 8'h00;                 // No field addressed yet
		end
		else if (envAddress)
		begin
			latchedAddr <= address;                   // Capture on address strobe
		end
	end

	//////////////////////////////////////////////////
	// Slot decode

	logic [7:0] pointerByte;                          // Pointer widened to address width

	assign pointerByte = {1'b0, pointer};

	// One comparator pair per slot; unmatched values select nothing
	genvar g;
	generate
		for (g = 0; g < fieldCount; g++)
		begin : slotDecode
			logic addrHit;                            // Latched address names this slot
			logic pointerHit;                         // Pointer names this slot

			assign addrHit    = (latchedAddr.raw == fieldAddr[g]);
			assign pointerHit = (pointerByte == fieldAddr[g]);

			assign fields[g].load   = recvData & addrHit;  // Load only during data receive
			assign fields[g].modify = modify & pointerHit; // Step only the pointed field
		end
	endgenerate

endmodule

`default_nettype wire

// ==== verilog/rtcFieldIf.sv ====
// Load and modify strobes, BCD value and three modports for one time field
`timescale 1ns/10ps
`default_nettype none

interface rtcFieldIf
	import rtcPkg::*;
	();

	logic    load;                                    // Bus data goes into this field
	logic    modify;                                  // Edit pointer names this field
	bcdByteT value;                                   // Current field contents

	// Decoder side
	modport select
	(
		output load,
		output modify
	);

	// Register side
	modport field
	(
		input  load,
		input  modify,
		output value
	);

	// Bus readback side
	modport readback
	(
		input value
	);

endinterface

`default_nettype wire

// ==== verilog/rtcPkg.sv ====
// Field count, RTC field addresses, BCD limits, readback default and bus word types
`default_nettype none

package rtcPkg;

	//////////////////////////////////////////////////
	// Field table sizes

	localparam int fieldCount = 9;                   // Year, date, time and timer fields

	//////////////////////////////////////////////////
	// RTC register addresses in slot order

	localparam logic [7:0] fieldAddr [fieldCount] = '{
		8'h26,                                        // Year
		8'h25,                                        // Month
		8'h24,                                        // Day
		8'h23,                                        // Hour
		8'h22,                                        // Minute
		8'h21,                                        // Second
		8'h43,                                        // Timer hour
		8'h42,                                        // Timer minute
		8'h41                                         // Timer second
	};

	//////////////////////////////////////////////////
	// BCD limits per slot

	localparam logic [7:0] fieldMin [fieldCount] = '{
		8'h00, 8'h01, 8'h01,                          // Year, month, day
		8'h00, 8'h00, 8'h00,                          // Hour, minute, second
		8'h00, 8'h00, 8'h00                           // Timer fields
	};

	localparam logic [7:0] fieldMax [fieldCount] = '{
		8'h99, 8'h12, 8'h31,                          // Year, month, day
		8'h23, 8'h59, 8'h59,                          // Hour, minute, second
		8'h23, 8'h59, 8'h59                           // Timer fields
	};

	localparam logic [7:0] noFieldWord = 8'hFF;      // Readback for an unmapped address

	//////////////////////////////////////////////////
	// Bus word types

	typedef struct packed {
		logic [3:0] tens;                             // Upper BCD digit
		logic [3:0] ones;                             // Lower BCD digit
	} bcdByteT;

	// One bus byte, seen as an address or as BCD data
	typedef union packed {
		logic [7:0] raw;                              // Address view
		bcdByteT    bcd;                              // Data view
	} busWordU;

endpackage

`default_nettype wire
